/* design/render_pkg.sv */
package render_pkg;

    // table slots; the saber candidate takes the index right after them
    localparam int NUM_BLOCKS = 12;

    // value held by an unused sliced-list slot
    localparam logic [7:0] EMPTY_ID = 8'hFF;

    typedef enum logic [2:0] {
        UP,
        DOWN,
        LEFT,
        RIGHT,
        ANY
    } direction_e;

    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [13:0] z;
        logic        color;
        direction_e  direction;
        logic [7:0]  id;
        logic        visible;
    } block_t;

    // saber tip position
    typedef struct packed {
        logic [11:0] x;
        logic [11:0] y;
        logic [13:0] z;
    } hand_t;

    typedef struct packed {
        logic [10:0] x;
        logic [9:0]  y;
    } pixel_t;

    typedef enum logic [1:0] {
        HIT_NONE,
        HIT_BLOCK,
        HIT_SABER
    } hit_kind_e;

    typedef struct packed {
        logic [3:0]  tag;
        logic [11:0] x;
        logic [11:0] y;
        logic [13:0] z;
        logic        eligible;
        logic        last;
    } candidate_t;

    typedef struct packed {
        logic [3:0]  tag;
        logic        hit;
        logic [13:0] z;
        logic        last;
    } probe_t;

    typedef struct packed {
        pixel_t      pixel;
        hit_kind_e   kind;
        logic [3:0]  index;
        block_t      block;
        logic [13:0] depth;
    } pick_t;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        DRAIN
    } sel_state_e;

endpackage

/* design/block_table.sv */
`timescale 1ns/1ps

module block_table (
    input  logic                                         clk_in,
    input  logic                                         rst_in,
    input  logic                                         block_wr,
    input  logic [3:0]                                   block_wr_index,
    input  render_pkg::block_t                           block_wr_data,
    input  logic                                         slice_wr,
    input  logic [7:0]                                   slice_id,
    output render_pkg::block_t [render_pkg::NUM_BLOCKS-1:0] blocks,
    output logic [render_pkg::NUM_BLOCKS-1:0]            eligible_mask
);

    localparam logic [3:0] LAST_SLOT = 4'(render_pkg::NUM_BLOCKS - 1);

    // ids of blocks already cut by the saber
    logic [render_pkg::NUM_BLOCKS-1:0][7:0] sliced;
    logic [3:0]                             slice_ptr;
    logic [render_pkg::NUM_BLOCKS-1:0]      id_sliced;

    // only the visible flag is cleared, the rest of a record is don't-care
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < render_pkg::NUM_BLOCKS; i++) begin
                blocks[i].visible <= 1'b0;
            end
        end else if (block_wr && (block_wr_index <= LAST_SLOT)) begin
            blocks[block_wr_index] <= block_wr_data;
        end
    end

    // sliced list fills round-robin, oldest entry gets overwritten
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < render_pkg::NUM_BLOCKS; i++) begin
                sliced[i] <= render_pkg::EMPTY_ID;
            end
            slice_ptr <= '0;
        end else if (slice_wr) begin
            sliced[slice_ptr] <= slice_id;
            if (slice_ptr == LAST_SLOT) begin
                slice_ptr <= '0;
            end else begin
                slice_ptr <= slice_ptr + 4'd1;
            end
        end
    end

    // every block id against every slot
    always_comb begin
        for (int b = 0; b < render_pkg::NUM_BLOCKS; b++) begin
            id_sliced[b] = 1'b0;
            for (int s = 0; s < render_pkg::NUM_BLOCKS; s++) begin
                if (sliced[s] == blocks[b].id) begin
                    id_sliced[b] = 1'b1;
                end
            end
            eligible_mask[b] = blocks[b].visible && !id_sliced[b];
        end
    end

endmodule

/* design/ray_block_test.sv */
`timescale 1ns/1ps

module ray_block_test #(
    parameter int HALF_SIZE = 64,
    parameter int Z_SHIFT   = 8
) (
    input  logic                   clk_in,
    input  logic                   rst_in,
    input  render_pkg::pixel_t     pixel,
    input  render_pkg::candidate_t cand,
    input  logic                   cand_valid,
    output render_pkg::probe_t     probe,
    output logic                   probe_valid
);

    // two's complement differences, wide enough for 12-bit minus 11-bit
    logic [12:0] dx_raw;
    logic [12:0] dy_raw;
    logic [12:0] dx_abs;
    logic [12:0] dy_abs;
    logic [13:0] z_shr;
    logic [13:0] half;

    logic        s1_valid;
    logic [12:0] s1_dx;
    logic [12:0] s1_dy;
    logic [13:0] s1_half;
    logic [3:0]  s1_tag;
    logic [13:0] s1_z;
    logic        s1_last;
    logic        s1_eligible;

    always_comb begin
        dx_raw = {1'b0, cand.x} - {2'b00, pixel.x};
        dy_raw = {1'b0, cand.y} - {3'b000, pixel.y};
        dx_abs = dx_raw[12] ? (13'd0 - dx_raw) : dx_raw;
        dy_abs = dy_raw[12] ? (13'd0 - dy_raw) : dy_raw;
        // farther away means a smaller footprint, down to nothing
        z_shr = cand.z >> Z_SHIFT;
        if (z_shr >= 14'(HALF_SIZE)) begin
            half = '0;
        end else begin
            half = 14'(HALF_SIZE) - z_shr;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid    <= 1'b0;
            probe_valid <= 1'b0;
        end else begin
            s1_valid    <= cand_valid;
            probe_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        s1_dx       <= dx_abs;
        s1_dy       <= dy_abs;
        s1_half     <= half;
        s1_tag      <= cand.tag;
        s1_z        <= cand.z;
        s1_last     <= cand.last;
        s1_eligible <= cand.eligible;

        // pixel within half-size on both axes, edges included
        probe.hit  <= s1_eligible && (s1_half != '0) && (s1_dx <= s1_half) && (s1_dy <= s1_half);
        probe.tag  <= s1_tag;
        probe.z    <= s1_z;
        probe.last <= s1_last;
    end

endmodule

/* design/block_selector.sv */
`timescale 1ns/1ps

module block_selector (
    input  logic                                         clk_in,
    input  logic                                         rst_in,
    input  render_pkg::pixel_t                           pixel,
    input  render_pkg::hand_t                            hand,
    input  render_pkg::block_t [render_pkg::NUM_BLOCKS-1:0] blocks,
    input  logic [render_pkg::NUM_BLOCKS-1:0]            eligible_mask,
    input  render_pkg::probe_t                           probe,
    input  logic                                         probe_valid,
    output render_pkg::candidate_t                       cand,
    output logic                                         cand_valid,
    output render_pkg::pick_t                            pick,
    output logic                                         valid_out,
    output logic                                         busy
);

    localparam logic [3:0] SABER_IDX = 4'(render_pkg::NUM_BLOCKS);

    render_pkg::sel_state_e state;
    render_pkg::pixel_t     last_pixel;
    logic [3:0]             idx;
    render_pkg::candidate_t next_cand;

    // running best over the probes seen so far
    render_pkg::hit_kind_e  best_kind;
    render_pkg::hit_kind_e  nxt_kind;
    logic [3:0]             best_index;
    logic [3:0]             nxt_index;
    logic [13:0]            best_depth;
    logic [13:0]            nxt_depth;

    assign busy = (state != render_pkg::IDLE);

    // blocks first, saber tip goes out last
    always_comb begin
        next_cand.tag = idx;
        if (idx == SABER_IDX) begin
            next_cand.x        = hand.x;
            next_cand.y        = hand.y;
            next_cand.z        = hand.z;
            next_cand.eligible = 1'b1;
            next_cand.last     = 1'b1;
        end else begin
            next_cand.x        = blocks[idx].x;
            next_cand.y        = blocks[idx].y;
            next_cand.z        = blocks[idx].z;
            next_cand.eligible = eligible_mask[idx];
            next_cand.last     = 1'b0;
        end
    end

    // saber beats everything, otherwise lower tag wins
    always_comb begin
        nxt_kind  = best_kind;
        nxt_index = best_index;
        nxt_depth = best_depth;
        if (probe_valid && probe.hit) begin
            if (probe.last) begin
                nxt_kind  = render_pkg::HIT_SABER;
                nxt_index = probe.tag;
                nxt_depth = probe.z;
            end else if ((best_kind == render_pkg::HIT_NONE) ||
                         ((best_kind == render_pkg::HIT_BLOCK) && (probe.tag < best_index))) begin
                nxt_kind  = render_pkg::HIT_BLOCK;
                nxt_index = probe.tag;
                nxt_depth = probe.z;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == render_pkg::ISSUE) begin
            cand <= next_cand;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state      <= render_pkg::IDLE;
            idx        <= '0;
            // out of reach of any real pixel so the first one is always taken
            last_pixel <= '{x: 11'h7FF, y: 10'h3FF};
            cand_valid <= 1'b0;
            valid_out  <= 1'b0;
            best_kind  <= render_pkg::HIT_NONE;
            best_index <= '0;
            best_depth <= '0;
            pick       <= '0;
        end else begin
            valid_out  <= 1'b0;
            cand_valid <= 1'b0;
            case (state)
                render_pkg::IDLE: begin
                    if (pixel != last_pixel) begin
                        last_pixel <= pixel;
                        idx        <= '0;
                        state      <= render_pkg::ISSUE;
                    end
                end
                render_pkg::ISSUE: begin
                    cand_valid <= 1'b1;
                    idx        <= idx + 4'd1;
                    if (idx == SABER_IDX) begin
                        state <= render_pkg::DRAIN;
                    end
                end
                // hold busy through the result cycle
                render_pkg::DRAIN: begin
                    if (valid_out) begin
                        state <= render_pkg::IDLE;
                    end
                end
                default: state <= render_pkg::IDLE;
            endcase

            if (probe_valid && probe.last) begin
                pick.pixel <= last_pixel;
                pick.kind  <= nxt_kind;
                pick.index <= nxt_index;
                pick.depth <= (nxt_kind == render_pkg::HIT_NONE) ? 14'd0 : nxt_depth;
                if (nxt_kind == render_pkg::HIT_BLOCK) begin
                    pick.block <= blocks[nxt_index];
                end else begin
                    pick.block <= '0;
                end
                valid_out  <= 1'b1;
                best_kind  <= render_pkg::HIT_NONE;
                best_index <= '0;
                best_depth <= '0;
            end else begin
                best_kind  <= nxt_kind;
                best_index <= nxt_index;
                best_depth <= nxt_depth;
            end
        end
    end

endmodule

/* design/block_render_top.sv */
`timescale 1ns/1ps

module block_render_top #(
    parameter int HALF_SIZE = 64,
    parameter int Z_SHIFT   = 8
) (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               block_wr,
    input  logic [3:0]         block_wr_index,
    input  render_pkg::block_t block_wr_data,
    input  logic               slice_wr,
    input  logic [7:0]         slice_id,
    input  render_pkg::hand_t  hand,
    input  render_pkg::pixel_t pixel,
    output render_pkg::pick_t  pick,
    output logic               valid_out,
    output logic               busy
);

    render_pkg::block_t [render_pkg::NUM_BLOCKS-1:0] blocks;
    logic [render_pkg::NUM_BLOCKS-1:0]               eligible_mask;
    render_pkg::candidate_t                          cand;
    logic                                            cand_valid;
    render_pkg::probe_t                              probe;
    logic                                            probe_valid;

    block_table u_table (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .block_wr      (block_wr),
        .block_wr_index(block_wr_index),
        .block_wr_data (block_wr_data),
        .slice_wr      (slice_wr),
        .slice_id      (slice_id),
        .blocks        (blocks),
        .eligible_mask (eligible_mask)
    );

    block_selector u_selector (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .pixel        (pixel),
        .hand         (hand),
        .blocks       (blocks),
        .eligible_mask(eligible_mask),
        .probe        (probe),
        .probe_valid  (probe_valid),
        .cand         (cand),
        .cand_valid   (cand_valid),
        .pick         (pick),
        .valid_out    (valid_out),
        .busy         (busy)
    );

    // pixel is held steady while busy, so the test unit reads it directly
    ray_block_test #(
        .HALF_SIZE(HALF_SIZE),
        .Z_SHIFT  (Z_SHIFT)
    ) u_test (
        .clk_in     (clk_in),
        .rst_in     (rst_in),
        .pixel      (pixel),
        .cand       (cand),
        .cand_valid (cand_valid),
        .probe      (probe),
        .probe_valid(probe_valid)
    );

endmodule

/* bench/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_in,
    output logic rst_in
);

    initial begin
        clk_in = 1'b0;
        forever #(PERIOD_NS / 2) clk_in = ~clk_in;
    end

    // reset drops on a rising edge, after the requested number of cycles
    initial begin
        rst_in = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_in);
        rst_in <= 1'b0;
    end

endmodule

/* bench/selector_properties.sv */
`timescale 1ns/1ps

module selector_properties (
    input logic              clk_in,
    input logic              rst_in,
    input logic              valid_out,
    input logic              busy,
    input logic              cand_valid,
    input render_pkg::pick_t pick
);

    // a result is a single-cycle pulse
    a_single_pulse: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out |=> !valid_out)
        else $error("valid_out stayed high for two cycles");

    a_valid_in_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        valid_out |-> busy)
        else $error("valid_out seen while busy was low");

    // no winner means no depth
    a_none_depth: assert property (@(posedge clk_in) disable iff (rst_in)
        (pick.kind == render_pkg::HIT_NONE) |-> (pick.depth == '0))
        else $error("HIT_NONE result carries a nonzero depth");

    a_cand_in_busy: assert property (@(posedge clk_in) disable iff (rst_in)
        cand_valid |-> busy)
        else $error("candidate issued while the selector was idle");

endmodule

bind block_selector selector_properties u_props (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .valid_out (valid_out),
    .busy      (busy),
    .cand_valid(cand_valid),
    .pick      (pick)
);

/* bench/render_tb.sv */
`timescale 1ns/1ps

module render_tb;

    // small enough that a far block can lose its footprint entirely
    localparam int HALF_SIZE  = 48;
    localparam int Z_SHIFT    = 8;
    localparam int LATENCY    = 16;
    localparam int WAIT_MAX   = 40;
    localparam int NUM_SCENES = 40;
    localparam render_pkg::hand_t FAR_HAND = '{x: 12'd4000, y: 12'd4000, z: 14'd0};

    logic                   clk_in;
    logic                   rst_in;
    logic                   block_wr;
    logic [3:0]             block_wr_index;
    render_pkg::block_t     block_wr_data;
    logic                   slice_wr;
    logic [7:0]             slice_id;
    render_pkg::hand_t      hand;
    render_pkg::pixel_t     pixel;
    render_pkg::pick_t      pick;
    logic                   valid_out;
    logic                   busy;

    // reference copy of the table
    render_pkg::block_t     m_blocks [render_pkg::NUM_BLOCKS];
    logic [7:0]             m_sliced [render_pkg::NUM_BLOCKS];
    int                     m_ptr;

    clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) u_clk (.clk_in(clk_in), .rst_in(rst_in));

    block_render_top #(
        .HALF_SIZE(HALF_SIZE),
        .Z_SHIFT  (Z_SHIFT)
    ) dut (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .block_wr      (block_wr),
        .block_wr_index(block_wr_index),
        .block_wr_data (block_wr_data),
        .slice_wr      (slice_wr),
        .slice_id      (slice_id),
        .hand          (hand),
        .pixel         (pixel),
        .pick          (pick),
        .valid_out     (valid_out),
        .busy          (busy)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    // square footprint that shrinks with distance
    function automatic logic covers(logic [11:0] cx, logic [11:0] cy, logic [13:0] cz,
                                    render_pkg::pixel_t p);
        int half;
        int dx;
        int dy;
        half = HALF_SIZE - (int'(cz) >> Z_SHIFT);
        dx = int'(cx) - int'(p.x);
        dy = int'(cy) - int'(p.y);
        dx = (dx < 0) ? -dx : dx;
        dy = (dy < 0) ? -dy : dy;
        return (half > 0) && (dx <= half) && (dy <= half);
    endfunction

    function automatic logic is_eligible(int b);
        logic cut;
        cut = 1'b0;
        foreach (m_sliced[s]) begin
            cut = cut | (m_sliced[s] == m_blocks[b].id);
        end
        return m_blocks[b].visible && !cut;
    endfunction

    function automatic render_pkg::pick_t expected_pick(render_pkg::pixel_t p);
        render_pkg::pick_t e;
        e = '0;
        e.pixel = p;
        e.kind  = render_pkg::HIT_NONE;
        if (covers(hand.x, hand.y, hand.z, p)) begin
            e.kind  = render_pkg::HIT_SABER;
            e.index = 4'(render_pkg::NUM_BLOCKS);
            e.depth = hand.z;
        end else begin
            // walk downward so the lowest index is the one left standing
            for (int b = render_pkg::NUM_BLOCKS - 1; b >= 0; b--) begin
                if (is_eligible(b) && covers(m_blocks[b].x, m_blocks[b].y, m_blocks[b].z, p)) begin
                    e.kind  = render_pkg::HIT_BLOCK;
                    e.index = 4'(b);
                    e.block = m_blocks[b];
                    e.depth = m_blocks[b].z;
                end
            end
        end
        return e;
    endfunction

    function automatic render_pkg::block_t make_block(int x, int y, int z, int id, logic vis);
        render_pkg::block_t b;
        b.x         = 12'(x);
        b.y         = 12'(y);
        b.z         = 14'(z);
        b.color     = 1'b0;
        b.direction = render_pkg::ANY;
        b.id        = 8'(id);
        b.visible   = vis;
        return b;
    endfunction

    // scatter within reach of the pixel so hits are common
    function automatic render_pkg::block_t near_block(render_pkg::pixel_t p);
        render_pkg::block_t b;
        b = make_block(int'(p.x) + int'($urandom_range(160, 0)) - 80,
                       int'(p.y) + int'($urandom_range(160, 0)) - 80,
                       int'($urandom_range(11000, 0)), int'($urandom_range(254, 0)),
                       $urandom_range(3, 0) != 0);
        b.color     = 1'($urandom_range(1, 0));
        b.direction = render_pkg::direction_e'(3'($urandom_range(4, 0)));
        return b;
    endfunction

    task automatic check_pick(input render_pkg::pick_t got, input render_pkg::pick_t exp,
                              input string what);
        if (got !== exp) begin
            abort_run({$sformatf("[FAIL] %0t %s: got kind %0d index %0d depth %0d block %h, ",
                                 $time, what, got.kind, got.index, got.depth, got.block),
                       $sformatf("expected kind %0d index %0d depth %0d block %h",
                                 exp.kind, exp.index, exp.depth, exp.block)});
        end
    endtask

    task automatic check_kind(input render_pkg::hit_kind_e got, input render_pkg::hit_kind_e exp,
                              input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t %s: got kind %0d, expected kind %0d",
                                $time, what, got, exp));
        end
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst_in) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_MAX) abort_run("timeout: reset was never released");
        end
    endtask

    task automatic write_block(input int idx, input render_pkg::block_t b);
        @(posedge clk_in);
        block_wr       <= 1'b1;
        block_wr_index <= 4'(idx);
        block_wr_data  <= b;
        @(posedge clk_in);
        block_wr <= 1'b0;
        m_blocks[idx] = b;
    endtask

    task automatic slice_block(input logic [7:0] id);
        @(posedge clk_in);
        slice_wr <= 1'b1;
        slice_id <= id;
        @(posedge clk_in);
        slice_wr <= 1'b0;
        m_sliced[m_ptr] = id;
        m_ptr = (m_ptr + 1) % render_pkg::NUM_BLOCKS;
    endtask

    task automatic place_hand(input render_pkg::hand_t h);
        @(posedge clk_in);
        hand <= h;
    endtask

    task automatic new_pixel(output render_pkg::pixel_t p);
        p = pixel;
        while (p == pixel) begin
            p.x = 11'($urandom_range(1900, 100));
            p.y = 10'($urandom_range(900, 100));
        end
    endtask

    // present a pixel and follow busy and valid_out through one lookup
    task automatic run_pixel(input render_pkg::pixel_t p, output render_pkg::pick_t got);
        int n;
        @(posedge clk_in);
        pixel <= p;
        n = 0;
        @(negedge clk_in);
        while (!busy) begin
            n++;
            if (n > WAIT_MAX) abort_run("timeout: busy never rose after a new pixel");
            @(negedge clk_in);
        end
        n = 0;
        while (!valid_out) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_MAX) abort_run("timeout: valid_out never came for the captured pixel");
        end
        if (n != LATENCY) begin
            abort_run($sformatf("[FAIL] %0t result latency %0d cycles, expected %0d",
                                $time, n, LATENCY));
        end
        got = pick;
        n = 0;
        while (busy) begin
            @(negedge clk_in);
            n++;
            if (n > WAIT_MAX) abort_run("timeout: busy stayed high after the result");
        end
    endtask

    task automatic hold_pixel_quiet(input render_pkg::pixel_t p);
        @(posedge clk_in);
        pixel <= p;
        for (int n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk_in);
            if (valid_out || busy) abort_run("an unchanged pixel started a new lookup");
        end
    endtask

    initial begin
        render_pkg::pixel_t p;
        render_pkg::pick_t  got;
        render_pkg::hand_t  h;
        int                 k;
        block_wr       <= 1'b0;
        block_wr_index <= '0;
        block_wr_data  <= '0;
        slice_wr       <= 1'b0;
        slice_id       <= '0;
        hand           <= FAR_HAND;
        // parked on the selector's reset value so nothing starts early
        pixel          <= '{x: 11'h7FF, y: 10'h3FF};
        m_ptr = 0;
        for (int i = 0; i < render_pkg::NUM_BLOCKS; i++) begin
            m_blocks[i] = '0;
            m_sliced[i] = render_pkg::EMPTY_ID;
        end
        void'($urandom(32'h8b147361));
        wait_reset_release();

        // nothing written yet
        p = '{x: 11'd640, y: 10'd360};
        run_pixel(p, got);
        check_kind(got.kind, render_pkg::HIT_NONE, "empty table");
        check_pick(got, expected_pick(p), "empty table");

        // saber over a stack of blocks
        for (int b = 0; b < 3; b++) begin
            write_block(b, make_block(500 + b, 300, 100 * b, b + 1, 1'b1));
        end
        place_hand('{x: 12'd500, y: 12'd300, z: 14'd900});
        p = '{x: 11'd500, y: 10'd300};
        run_pixel(p, got);
        check_kind(got.kind, render_pkg::HIT_SABER, "saber over blocks");
        check_pick(got, expected_pick(p), "saber over blocks");

        // slicing walks down the priority of two stacked blocks
        place_hand(FAR_HAND);
        for (int b = 0; b < render_pkg::NUM_BLOCKS; b++) begin
            write_block(b, make_block(700, 400, 500, 20 + b, (b == 3) || (b == 7)));
        end
        p = '{x: 11'd700, y: 10'd400};
        run_pixel(p, got);
        check_kind(got.kind, render_pkg::HIT_BLOCK, "before slicing");
        check_pick(got, expected_pick(p), "before slicing");
        slice_block(8'd23);
        p.x = 11'd701;
        run_pixel(p, got);
        check_pick(got, expected_pick(p), "first block sliced");
        slice_block(8'd27);
        p.x = 11'd702;
        run_pixel(p, got);
        check_kind(got.kind, render_pkg::HIT_NONE, "both blocks sliced");
        check_pick(got, expected_pick(p), "both blocks sliced");
        // a full lap of the list pushes out both earlier slices
        for (int i = 0; i < render_pkg::NUM_BLOCKS; i++) begin
            slice_block(8'(100 + i));
        end
        p.x = 11'd703;
        run_pixel(p, got);
        check_kind(got.kind, render_pkg::HIT_BLOCK, "slice list wrapped");
        check_pick(got, expected_pick(p), "slice list wrapped");

        // too far away to cover anything
        write_block(0, make_block(1500, 700, 16383, 50, 1'b1));
        p = '{x: 11'd1500, y: 10'd700};
        run_pixel(p, got);
        check_kind(got.kind, render_pkg::HIT_NONE, "far block");
        check_pick(got, expected_pick(p), "far block");
        hold_pixel_quiet(p);

        for (int t = 0; t < NUM_SCENES; t++) begin
            new_pixel(p);
            for (int b = 0; b < render_pkg::NUM_BLOCKS; b++) begin
                write_block(b, near_block(p));
            end
            if ($urandom_range(3, 0) == 0) begin
                h = '{x: {1'b0, p.x}, y: {2'b00, p.y}, z: 14'($urandom_range(4000, 0))};
            end else begin
                h = FAR_HAND;
            end
            place_hand(h);
            if ($urandom_range(1, 0) == 1) begin
                k = $urandom_range(render_pkg::NUM_BLOCKS - 1, 0);
                slice_block(m_blocks[k].id);
            end
            run_pixel(p, got);
            check_pick(got, expected_pick(p), "random scene");
        end

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sources.f */
design/render_pkg.sv
design/block_table.sv
design/ray_block_test.sv
design/block_selector.sv
design/block_render_top.sv
bench/clock_gen.sv
bench/selector_properties.sv
bench/render_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= render_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
